//--- logic/alu_pkg.sv
package alu_pkg;

    // data path width
    localparam int XLEN = 64;

    // operation codes carried from decode
    typedef enum logic [4:0] {
        ALU_ADD      = 5'd0,
        ALU_SUB      = 5'd1,
        ALU_RETURN_A = 5'd2,
        ALU_RETURN_B = 5'd3,
        ALU_XOR      = 5'd4,
        ALU_OR       = 5'd5,
        ALU_AND      = 5'd6,
        ALU_SLL      = 5'd7,
        ALU_SRL      = 5'd8,
        ALU_SRA      = 5'd9,
        ALU_SLT      = 5'd10,
        ALU_SLTU     = 5'd11,
        ALU_EQ       = 5'd12,
        ALU_GE       = 5'd13,
        ALU_GEU      = 5'd14,
        // handled by the iterative unit
        ALU_MUL      = 5'd15,
        ALU_DIV      = 5'd16,
        ALU_DIVU     = 5'd17,
        ALU_REM      = 5'd18,
        ALU_REMU     = 5'd19
    } alu_op_e;

    // first operand source
    typedef enum logic [1:0] {
        SEL_A_PC  = 2'd0,
        SEL_A_RS1 = 2'd1
    } sel_a_e;

    // second operand source, code 3 falls back to imm
    typedef enum logic [1:0] {
        SEL_B_IMM = 2'd0,
        SEL_B_RS2 = 2'd1,
        SEL_B_CSR = 2'd2
    } sel_b_e;

    // true for operations that go to the multi-cycle unit
    function automatic logic is_muldiv(alu_op_e op);
        return op inside {ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    endfunction

endpackage

//--- logic/exec_pkg.sv
package exec_pkg;

    // raw issue bundle as it arrives from decode
    typedef struct packed {
        alu_pkg::alu_op_e         op;
        alu_pkg::sel_a_e          sel_a;
        alu_pkg::sel_b_e          sel_b;
        // word flag, rs1 taken as 32 bits
        logic                     word;
        logic [alu_pkg::XLEN-1:0] pc;
        logic [alu_pkg::XLEN-1:0] rs1;
        logic [alu_pkg::XLEN-1:0] rs2;
        logic [alu_pkg::XLEN-1:0] csr;
        logic [alu_pkg::XLEN-1:0] imm;
    } issue_t;

    // operands after selection and trimming
    typedef struct packed {
        alu_pkg::alu_op_e         op;
        logic                     word;
        logic [alu_pkg::XLEN-1:0] a;
        logic [alu_pkg::XLEN-1:0] b;
    } operand_t;

    // value written back by either result source
    typedef struct packed {
        logic [alu_pkg::XLEN-1:0] value;
    } result_t;

endpackage

//--- logic/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid bit, dropped on reset or flush
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload only moves when a new entry arrives
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

//--- logic/operand_select.sv
module operand_select (
    input  exec_pkg::issue_t   issue,
    output exec_pkg::operand_t operands
);

    logic [alu_pkg::XLEN-1:0] rs1_trim;

    always_comb begin
        // word form keeps the low half of rs1, upper half zero
        if (issue.word) begin
            rs1_trim = {{(alu_pkg::XLEN-32){1'b0}}, issue.rs1[31:0]};
        end else begin
            rs1_trim = issue.rs1;
        end

        operands.op   = issue.op;
        operands.word = issue.word;

        // operand a is pc or rs1
        if (issue.sel_a == alu_pkg::SEL_A_RS1) begin
            operands.a = rs1_trim;
        end else begin
            operands.a = issue.pc;
        end

        // operand b is rs2, csr or imm
        case (issue.sel_b)
            alu_pkg::SEL_B_RS2: begin
                operands.b = issue.rs2;
            end
            alu_pkg::SEL_B_CSR: begin
                operands.b = issue.csr;
            end
            default: begin
                operands.b = issue.imm;
            end
        endcase
    end

endmodule

//--- logic/int_alu.sv
module int_alu (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               in_valid,
    input  exec_pkg::operand_t operands,
    output logic               done,
    output exec_pkg::result_t  result
);

    localparam int XLEN = alu_pkg::XLEN;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [5:0]      shamt;
    logic [31:0]     sra_word;
    logic [XLEN-1:0] value;

    always_comb begin
        a     = operands.a;
        b     = operands.b;
        // only the low 6 bits of b count as shift amount
        shamt = b[5:0];
        // word SRA works on the low half, then zero-extends
        sra_word = $signed(a[31:0]) >>> shamt;

        case (operands.op)
            alu_pkg::ALU_ADD:      value = a + b;
            alu_pkg::ALU_SUB:      value = a - b;
            alu_pkg::ALU_RETURN_A: value = a;
            alu_pkg::ALU_RETURN_B: value = b;
            alu_pkg::ALU_XOR:      value = a ^ b;
            alu_pkg::ALU_OR:       value = a | b;
            alu_pkg::ALU_AND:      value = a & b;
            alu_pkg::ALU_SLL:      value = a << shamt;
            alu_pkg::ALU_SRL:      value = a >> shamt;
            alu_pkg::ALU_SRA: begin
                if (operands.word) begin
                    value = {{(XLEN-32){1'b0}}, sra_word};
                end else begin
                    value = $signed(a) >>> shamt;
                end
            end
            // compares give 1 or 0
            alu_pkg::ALU_SLT:  value = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_pkg::ALU_SLTU: value = {{(XLEN-1){1'b0}}, a < b};
            alu_pkg::ALU_EQ:   value = {{(XLEN-1){1'b0}}, a == b};
            alu_pkg::ALU_GE:   value = {{(XLEN-1){1'b0}}, $signed(a) >= $signed(b)};
            alu_pkg::ALU_GEU:  value = {{(XLEN-1){1'b0}}, a >= b};
            // mul/div codes and unknown codes land here
            default:           value = '0;
        endcase
    end

    // done only for single-cycle work, mul/div has its own pulse
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            done <= 1'b0;
        end else begin
            done <= in_valid && !alu_pkg::is_muldiv(operands.op);
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            result.value <= value;
        end
    end

endmodule

//--- logic/mul_div_unit.sv
module mul_div_unit #(
    parameter int DIV_ENABLE = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               start,
    input  exec_pkg::operand_t operands,
    output logic               busy,
    output logic               done,
    output exec_pkg::result_t  result
);

    localparam int XLEN = alu_pkg::XLEN;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,
        ST_DIV,
        ST_FINISH
    } state_e;

    state_e state;

    // acc is product or partial remainder
    // opnd is multiplicand or divisor magnitude
    // shreg is multiplier or quotient under construction
    logic [XLEN-1:0] acc;
    logic [XLEN-1:0] opnd;
    logic [XLEN-1:0] shreg;
    logic [5:0]      count;
    logic            neg_q;
    logic            neg_r;
    logic            rem_sel;

    // decode at start
    logic            is_div_op;
    logic            is_signed_op;
    logic            op_is_rem;
    logic            a_neg;
    logic            b_neg;
    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;

    // one iteration of either algorithm
    logic [XLEN-1:0] acc_add;
    logic [XLEN:0]   rem_shift;
    logic            rem_ge;
    logic [XLEN-1:0] rem_next;
    logic [XLEN-1:0] quo_next;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;

    always_comb begin
        is_div_op    = operands.op inside {alu_pkg::ALU_DIV, alu_pkg::ALU_DIVU,
                                           alu_pkg::ALU_REM, alu_pkg::ALU_REMU};
        is_signed_op = operands.op inside {alu_pkg::ALU_DIV, alu_pkg::ALU_REM};
        op_is_rem    = operands.op inside {alu_pkg::ALU_REM, alu_pkg::ALU_REMU};
        a_neg        = is_signed_op && operands.a[XLEN-1];
        b_neg        = is_signed_op && operands.b[XLEN-1];
        a_mag        = a_neg ? -operands.a : operands.a;
        b_mag        = b_neg ? -operands.b : operands.b;
    end

    always_comb begin
        // shift-add step
        acc_add   = shreg[0] ? acc + opnd : acc;
        // restoring step, bring down next dividend bit
        rem_shift = {acc, shreg[XLEN-1]};
        rem_ge    = rem_shift >= {1'b0, opnd};
        rem_next  = rem_ge ? rem_shift[XLEN-1:0] - opnd : rem_shift[XLEN-1:0];
        quo_next  = {shreg[XLEN-2:0], rem_ge};
        // sign fix on the last step
        // min / -1 already gives 2^63 here, which is the dividend
        quo_fix   = neg_q ? -quo_next : quo_next;
        rem_fix   = neg_r ? -rem_next : rem_next;
    end

    // control, busy falls on the same edge done rises
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= ST_IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        busy <= 1'b1;
                        if (!is_div_op) begin
                            state <= ST_MUL;
                        end else if (DIV_ENABLE == 0 || operands.b == '0) begin
                            state <= ST_FINISH;
                        end else begin
                            state <= ST_DIV;
                        end
                    end
                end
                ST_MUL: begin
                    // stop once no multiplier bits remain
                    if (shreg[XLEN-1:1] == '0) begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                ST_DIV: begin
                    if (count == '0) begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (start) begin
                    count   <= 6'd63;
                    neg_q   <= a_neg ^ b_neg;
                    neg_r   <= a_neg;
                    rem_sel <= op_is_rem;
                    acc     <= '0;
                    if (is_div_op) begin
                        opnd  <= b_mag;
                        shreg <= a_mag;
                    end else begin
                        opnd  <= operands.a;
                        shreg <= operands.b;
                    end
                    // early answers for disabled divide and zero divisor
                    if (DIV_ENABLE == 0) begin
                        result.value <= '0;
                    end else begin
                        result.value <= op_is_rem ? operands.a : '1;
                    end
                end
            end
            ST_MUL: begin
                acc          <= acc_add;
                opnd         <= opnd << 1;
                shreg        <= shreg >> 1;
                result.value <= acc_add;
            end
            ST_DIV: begin
                acc          <= rem_next;
                shreg        <= quo_next;
                count        <= count - 6'd1;
                result.value <= rem_sel ? rem_fix : quo_fix;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- logic/exec_top.sv
module exec_top #(
    parameter int DIV_ENABLE = 1
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              issue_valid,
    input  exec_pkg::issue_t  issue,
    output logic              result_valid,
    output exec_pkg::result_t result,
    output logic              busy
);

    logic               issue_q_valid;
    exec_pkg::issue_t   issue_q_data;
    exec_pkg::operand_t operands_d;
    logic               operand_q_valid;
    exec_pkg::operand_t operand_q_data;

    logic               md_pending;
    logic               issue_accept;
    logic               md_start;
    logic               alu_done;
    logic               md_done;
    exec_pkg::result_t  alu_result;
    exec_pkg::result_t  md_result;

    // a mul/div anywhere in the pipe blocks new issues
    assign md_pending = busy
                     || (issue_q_valid && alu_pkg::is_muldiv(issue_q_data.op))
                     || (operand_q_valid && alu_pkg::is_muldiv(operand_q_data.op));
    assign issue_accept = issue_valid && !md_pending;

    stage_reg #(.payload_t(exec_pkg::issue_t)) issue_q (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (issue_accept),
        .in_data   (issue),
        .out_valid (issue_q_valid),
        .out_data  (issue_q_data)
    );

    operand_select u_operand_select (
        .issue    (issue_q_data),
        .operands (operands_d)
    );

    stage_reg #(.payload_t(exec_pkg::operand_t)) operand_q (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (issue_q_valid),
        .in_data   (operands_d),
        .out_valid (operand_q_valid),
        .out_data  (operand_q_data)
    );

    int_alu u_int_alu (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .in_valid (operand_q_valid),
        .operands (operand_q_data),
        .done     (alu_done),
        .result   (alu_result)
    );

    // mul/div leaves operand_q straight into the iterative unit
    assign md_start = operand_q_valid && alu_pkg::is_muldiv(operand_q_data.op);

    mul_div_unit #(.DIV_ENABLE(DIV_ENABLE)) u_mul_div_unit (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .start    (md_start),
        .operands (operand_q_data),
        .busy     (busy),
        .done     (md_done),
        .result   (md_result)
    );

    // the two done pulses never overlap
    assign result_valid = alu_done || md_done;
    assign result       = md_done ? md_result : alu_result;

endmodule

//--- sim/exec_props.sv
module exec_props (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic issue_valid,
    input logic result_valid,
    input logic busy,
    input logic alu_done,
    input logic md_done
);

    // no new work while the iterative unit runs
    no_issue_while_busy: assert property (
        @(posedge clk) disable iff (reset) issue_valid |-> !busy
    ) else $error("issue_valid strobed while busy");

    // outputs stay quiet for four cycles after reset
    quiet_after_reset: assert property (
        @(posedge clk) disable iff (reset)
        ($past(reset, 1) || $past(reset, 2) || $past(reset, 3) || $past(reset, 4))
        |-> (!result_valid && !busy)
    ) else $error("result_valid or busy active right after reset");

    busy_falls_with_done: assert property (
        @(posedge clk) disable iff (reset) $fell(busy) |-> (md_done || $past(flush))
    ) else $error("busy dropped without done or flush");

    // ALU and mul/div results share one output
    single_result_source: assert property (
        @(posedge clk) disable iff (reset) !(alu_done && md_done)
    ) else $error("ALU and mul/div done pulses overlap");

endmodule

bind exec_top exec_props u_exec_props (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .issue_valid  (issue_valid),
    .result_valid (result_valid),
    .busy         (busy),
    .alu_done     (alu_done),
    .md_done      (md_done)
);

//--- sim/exec_tb.sv
module exec_tb;

    localparam int NUM_VEC = 26;
    // flush, op, sel_a, sel_b, word, pc, rs1, rs2, csr, imm, expected
    localparam int FIELDS  = 11;
    localparam int LIMIT   = NUM_VEC * 80 + 100;

    logic              clk;
    logic              reset;
    logic              flush;
    logic              issue_valid;
    exec_pkg::issue_t  issue;
    logic              result_valid;
    exec_pkg::result_t result;
    logic              busy;

    logic [63:0]       golden [0:NUM_VEC*FIELDS-1];
    exec_pkg::result_t exp_values[$];
    int                exp_cycles[$];
    int                cycle_count = 0;
    logic [63:0]       rng_state = 64'd6227;

    exec_top #(.DIV_ENABLE(1)) DUT (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (result_valid),
        .result       (result),
        .busy         (busy)
    );

    always #4 clk = ~clk;

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    // operand a of a word vector, rs1 cut to 32 bits and zero-extended
    function automatic exec_pkg::result_t expected_word_a(input int base);
        exec_pkg::result_t r;
        if (alu_pkg::sel_a_e'(golden[base+2][1:0]) == alu_pkg::SEL_A_RS1) begin
            r.value = {32'h0, golden[base+6][31:0]};
        end else begin
            r.value = golden[base+5];
        end
        return r;
    endfunction

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_result(input exec_pkg::result_t got, input exec_pkg::result_t want);
        if (got !== want) begin
            $display("FAILED result: got %h expected %h", got.value, want.value);
            abort_run();
        end
    endtask

    task automatic compare_busy(input logic got, input logic want);
        if (got !== want) begin
            $display("FAILED busy: got %h expected %h", got, want);
            abort_run();
        end
    endtask

    // drive one vector a unit after the edge, left high for back-to-back use
    task automatic send_vector(input int idx);
        int base;
        base = idx * FIELDS;
        @(posedge clk);
        #1;
        issue_valid = 1'b1;
        issue.op    = alu_pkg::alu_op_e'(golden[base+1][4:0]);
        issue.sel_a = alu_pkg::sel_a_e'(golden[base+2][1:0]);
        issue.sel_b = alu_pkg::sel_b_e'(golden[base+3][1:0]);
        issue.word  = golden[base+4][0];
        issue.pc    = golden[base+5];
        issue.rs1   = golden[base+6];
        issue.rs2   = golden[base+7];
        issue.csr   = golden[base+8];
        issue.imm   = golden[base+9];
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_values.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // watchdog, also the cycle reference for ALU latency
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > LIMIT) begin
            $display("timeout: simulation ran past %0d cycles", LIMIT);
            abort_run();
        end
    end

    // results are checked in issue order at the falling edge
    always @(negedge clk) begin
        exec_pkg::result_t want;
        int                due;
        if (!reset && result_valid === 1'b1) begin
            if (exp_values.size() == 0) begin
                $display("result_valid came with no result outstanding at cycle %0d",
                         cycle_count);
                abort_run();
            end else begin
                want = exp_values.pop_front();
                due  = exp_cycles.pop_front();
                compare_result(result, want);
                if (due >= 0 && due != cycle_count) begin
                    $display("ALU result came at cycle %0d instead of cycle %0d",
                             cycle_count, due);
                    abort_run();
                end
            end
        end
    end

    initial begin
        int   base;
        int   gap;
        logic md_now;
        clk         = 1'b0;
        reset       = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        $readmemh("sim/exec_golden.hex", golden);
        if (^golden[NUM_VEC*FIELDS-1] === 1'bx) begin
            $display("golden vector file is missing or shorter than expected");
            abort_run();
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < NUM_VEC; i++) begin
            base   = i * FIELDS;
            md_now = alu_pkg::is_muldiv(alu_pkg::alu_op_e'(golden[base+1][4:0]));
            if (golden[base][0]) begin
                // flushed work, nothing is queued
                idle_cycle();
                wait_drain();
                if (md_now) begin
                    send_vector(i);
                    idle_cycle();
                    repeat (2) @(posedge clk);
                    #1;
                    compare_busy(busy, 1'b1);
                    repeat (4) idle_cycle();
                end else begin
                    // three ALU ops in flight when flush hits
                    send_vector(i);
                    send_vector(i);
                    send_vector(i);
                end
                flush = 1'b1;
                idle_cycle();
                flush = 1'b0;
                compare_busy(busy, 1'b0);
                repeat (6) idle_cycle();
            end else begin
                if (md_now) begin
                    idle_cycle();
                    wait_drain();
                end
                send_vector(i);
                exp_values.push_back(exec_pkg::result_t'(golden[base+10]));
                exp_cycles.push_back(md_now ? -1 : cycle_count + 3);
                if (md_now) begin
                    idle_cycle();
                    repeat (2) @(posedge clk);
                    #1;
                    compare_busy(busy, 1'b1);
                    wait_drain();
                    compare_busy(busy, 1'b0);
                end else begin
                    if (golden[base+4][0]) begin
                        // same word vector again, echoing operand a
                        send_vector(i);
                        issue.op = alu_pkg::ALU_RETURN_A;
                        exp_values.push_back(expected_word_a(base));
                        exp_cycles.push_back(cycle_count + 3);
                    end
                    rng_state = xorshift(rng_state);
                    gap       = int'(rng_state[1:0]);
                    repeat (gap) idle_cycle();
                end
            end
        end

        idle_cycle();
        wait_drain();
        repeat (8) idle_cycle();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- sim/exec_golden.hex
// columns: flush op sel_a sel_b word pc rs1 rs2 csr imm expected
// op: 00 add 01 sub 03 ret_b 04 xor 0a slt 0b sltu 0f mul 10 div 11 divu 12 rem
0 00 1 1 0 0 1234 fff 0 0 2233
0 01 1 1 0 0 5 8 0 0 fffffffffffffffd
0 00 0 0 0 80000000 0 0 0 fffffffffffffffc 7ffffffc
0 03 1 2 0 0 0 0 deadbeefcafef00d 0 deadbeefcafef00d
0 04 1 1 0 0 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 0 f0f0f0f0f0f0f0f0
0 0a 1 1 0 0 ffffffffffffffff 1 0 0 1
0 0b 1 1 0 0 ffffffffffffffff 1 0 0 0
0 07 1 1 0 0 1 143 0 0 8
0 08 1 0 0 0 8000000000000000 0 0 7c 8
0 09 1 1 1 0 ffffffff80000000 4 0 0 f8000000
0 09 1 1 0 0 8000000000000000 4 0 0 f800000000000000
0 0e 1 1 0 0 1 ffffffffffffffff 0 0 0
0 0f 1 1 0 0 7 6 0 0 2a
0 0f 1 1 0 0 ffffffffffffffff ffffffffffffffff 0 0 1
0 0f 1 1 0 0 0000000100000001 0000000100000001 0 0 0000000200000001
0 10 1 1 0 0 ffffffffffffff9c 7 0 0 fffffffffffffff2
0 12 1 1 0 0 ffffffffffffff9c 7 0 0 fffffffffffffffe
0 11 1 1 0 0 64 7 0 0 e
0 10 1 1 0 0 1234 0 0 0 ffffffffffffffff
0 12 1 1 0 0 1234 0 0 0 1234
0 10 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 8000000000000000
0 12 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 0
1 11 1 1 0 0 ffffffffffffffff 3 0 0 0
0 06 1 1 0 0 f0f0 ff00 0 0 f000
1 05 1 1 0 0 1 2 0 0 0
0 0c 1 1 0 0 abcd abcd 0 0 1

//--- files.f
logic/alu_pkg.sv
logic/exec_pkg.sv
logic/stage_reg.sv
logic/operand_select.sv
logic/int_alu.sv
logic/mul_div_unit.sv
logic/exec_top.sv
sim/exec_props.sv
sim/exec_tb.sv

//--- Makefile
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module exec_tb -o exec_sim

run: build
	./obj_dir/exec_sim | tee $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

lint:
	verilator --lint-only --timing --assert -f files.f --top-module exec_tb

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
